//--- logic/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// integer data path width.
`define XLEN 32

// register file address width, x0..x31.
`define RADDR_W 5

// cycles from a multiply start to ready, at least 1.
`define MUL_LATENCY 2

`endif

//--- logic/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

  // which unit produces the result.
  typedef enum logic [1:0] {
    unit_alu = 2'd0,
    unit_mul = 2'd1,
    unit_div = 2'd2
  } exec_unit_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    mul_mul    = 2'd0, // low word.
    mul_mulh   = 2'd1, // signed x signed, high word.
    mul_mulhsu = 2'd2, // signed x unsigned, high word.
    mul_mulhu  = 2'd3  // unsigned x unsigned, high word.
  } mul_op_e;

  typedef enum logic [1:0] {
    div_div  = 2'd0,
    div_divu = 2'd1,
    div_rem  = 2'd2,
    div_remu = 2'd3
  } div_op_e;

  // decoded request entering the execute stage.
  typedef struct packed {
    logic                valid;
    logic                clear;  // squash, never retires.
    exec_unit_e          unit;
    alu_op_e             alu_op;
    mul_op_e             mul_op;
    div_op_e             div_op;
    logic                rden1;
    logic                rden2;  // low selects imm for the alu.
    logic [`XLEN-1:0]    rdata1;
    logic [`XLEN-1:0]    rdata2;
    logic [`XLEN-1:0]    imm;
    logic [`RADDR_W-1:0] waddr;
  } exec_req_t;

  // operands toward the multiplier or the divider.
  typedef struct packed {
    logic             enable;
    logic [1:0]       op;     // mul_op_e or div_op_e.
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
  } muldiv_in_t;

  typedef struct packed {
    logic             ready;  // one cycle pulse.
    logic [`XLEN-1:0] result;
  } muldiv_out_t;

  typedef struct packed {
    logic                retired;
    logic                wren;
    logic [`RADDR_W-1:0] waddr;
    logic [`XLEN-1:0]    wdata;
  } writeback_t;

  localparam exec_req_t init_exec_req = '0;

endpackage

//--- logic/mul_unit.sv
`include "exec_cfg.svh"

module mul_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  exec_pkg::muldiv_in_t   mul_in,
  output exec_pkg::muldiv_out_t  mul_out
);
  import exec_pkg::*;

  mul_op_e                   op;
  logic                      a_sgn;
  logic                      b_sgn;
  logic signed [`XLEN:0]     a_ext;
  logic signed [`XLEN:0]     b_ext;
  logic signed [2*`XLEN+1:0] prod_full;
  logic                      start;
  logic                      busy;

  // one valid bit, product and op tag per pipeline stage.
  logic [`MUL_LATENCY-1:0]   vld_q;
  logic [2*`XLEN-1:0]        prod_q [`MUL_LATENCY];
  mul_op_e                   op_q [`MUL_LATENCY];

  always_comb begin
    op = mul_op_e'(mul_in.op);
    a_sgn = (op == mul_mulh) || (op == mul_mulhsu);
    b_sgn = (op == mul_mulh);
    a_ext = {a_sgn & mul_in.rdata1[`XLEN-1], mul_in.rdata1}; // 33 bit signed view.
    b_ext = {b_sgn & mul_in.rdata2[`XLEN-1], mul_in.rdata2};
    prod_full = a_ext * b_ext;
    start = mul_in.enable & ~busy;
  end

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      vld_q <= '0;
      busy <= 1'b0;
    end else begin
      vld_q[0] <= start;
      for (int i = 1; i < `MUL_LATENCY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
      if (start) begin
        busy <= 1'b1;
      end else if (vld_q[`MUL_LATENCY-1]) begin
        busy <= 1'b0; // free again after the ready cycle.
      end
    end
  end

  always_ff @(posedge clk) begin
    prod_q[0] <= prod_full[2*`XLEN-1:0];
    op_q[0] <= op;
    for (int i = 1; i < `MUL_LATENCY; i++) begin
      prod_q[i] <= prod_q[i-1];
      op_q[i] <= op_q[i-1];
    end
  end

  always_comb begin
    mul_out.ready = vld_q[`MUL_LATENCY-1];
    if (op_q[`MUL_LATENCY-1] == mul_mul) begin
      mul_out.result = prod_q[`MUL_LATENCY-1][`XLEN-1:0];
    end else begin
      mul_out.result = prod_q[`MUL_LATENCY-1][2*`XLEN-1:`XLEN];
    end
  end

endmodule

//--- logic/div_unit.sv
`include "exec_cfg.svh"

module div_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  exec_pkg::muldiv_in_t   div_in,
  output exec_pkg::muldiv_out_t  div_out
);
  import exec_pkg::*;

  localparam int CNT_W = $clog2(`XLEN);
  localparam logic [`XLEN-1:0] MIN_NEG = {1'b1, {(`XLEN-1){1'b0}}};

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_done
  } div_state_e;

  div_state_e       state;
  logic [CNT_W-1:0] cnt;

  div_op_e          op;
  logic             is_signed;
  logic             start;
  logic [`XLEN-1:0] abs_a;
  logic [`XLEN-1:0] abs_b;

  div_op_e          op_q;
  logic [`XLEN-1:0] dvd_q;  // original dividend.
  logic [`XLEN-1:0] dvs_q;  // divisor magnitude.
  logic [`XLEN-1:0] quo_q;
  logic [`XLEN-1:0] rem_q;
  logic             neg_q;
  logic             neg_r;
  logic             dbz_q;
  logic             ovf_q;

  logic [`XLEN:0]   rem_sh;
  logic [`XLEN+1:0] diff;
  logic             borrow;
  logic [`XLEN-1:0] quo_fix;
  logic [`XLEN-1:0] rem_fix;
  logic [`XLEN-1:0] quo_res;
  logic [`XLEN-1:0] rem_res;

  always_comb begin
    op = div_op_e'(div_in.op);
    is_signed = (op == div_div) || (op == div_rem);
    abs_a = (is_signed && div_in.rdata1[`XLEN-1]) ? -div_in.rdata1 : div_in.rdata1;
    abs_b = (is_signed && div_in.rdata2[`XLEN-1]) ? -div_in.rdata2 : div_in.rdata2;
    start = div_in.enable && (state == div_idle);

    // one restoring step.
    rem_sh = {rem_q, quo_q[`XLEN-1]};
    diff = {1'b0, rem_sh} - {2'b00, dvs_q};
    borrow = diff[`XLEN+1];
  end

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      state <= div_idle;
      cnt <= '0;
    end else begin
      unique case (state)
        div_idle: begin
          if (start) begin
            state <= div_run;
            cnt <= '0;
          end
        end
        div_run: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(`XLEN - 1)) begin
            state <= div_done;
          end
        end
        div_done: state <= div_idle; // ready for one cycle.
        default:  state <= div_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q <= op;
      dvd_q <= div_in.rdata1;
      dvs_q <= abs_b;
      quo_q <= abs_a; // dividend shifts out as quotient shifts in.
      rem_q <= '0;
      neg_q <= is_signed & (div_in.rdata1[`XLEN-1] ^ div_in.rdata2[`XLEN-1]);
      neg_r <= is_signed & div_in.rdata1[`XLEN-1];
      dbz_q <= (div_in.rdata2 == '0);
      ovf_q <= is_signed && (div_in.rdata1 == MIN_NEG) && (div_in.rdata2 == '1);
    end else if (state == div_run) begin
      quo_q <= {quo_q[`XLEN-2:0], ~borrow};
      rem_q <= borrow ? rem_sh[`XLEN-1:0] : diff[`XLEN-1:0];
    end
  end

  always_comb begin
    quo_fix = neg_q ? -quo_q : quo_q;
    rem_fix = neg_r ? -rem_q : rem_q;
    if (dbz_q) begin
      quo_res = '1;
      rem_res = dvd_q;
    end else if (ovf_q) begin
      quo_res = dvd_q;
      rem_res = '0;
    end else begin
      quo_res = quo_fix;
      rem_res = rem_fix;
    end
    div_out.ready = (state == div_done);
    if ((op_q == div_rem) || (op_q == div_remu)) begin
      div_out.result = rem_res;
    end else begin
      div_out.result = quo_res;
    end
  end

endmodule

//--- logic/execute_stage.sv
`include "exec_cfg.svh"

module execute_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  exec_pkg::exec_req_t    req,
  output exec_pkg::muldiv_in_t   mul_in,
  input  exec_pkg::muldiv_out_t  mul_out,
  output exec_pkg::muldiv_in_t   div_in,
  input  exec_pkg::muldiv_out_t  div_out,
  output logic                   stall,
  output exec_pkg::writeback_t   wb
);
  import exec_pkg::*;

  localparam int SH_W = $clog2(`XLEN);

  exec_req_t        r_req;   // held request.
  logic             r_stall;
  exec_req_t        cur;
  logic             live;
  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [`XLEN-1:0] alu_b;
  logic [SH_W-1:0]  shamt;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] wdata;

  always_comb begin
    cur = r_stall ? r_req : req; // req is ignored while stalled.
    live = cur.valid & ~cur.clear;
    op1 = cur.rden1 ? cur.rdata1 : '0;
    op2 = cur.rden2 ? cur.rdata2 : '0;
    alu_b = cur.rden2 ? op2 : cur.imm;
    shamt = alu_b[SH_W-1:0];
  end

  always_comb begin
    unique case (cur.alu_op)
      alu_add:  alu_res = op1 + alu_b;
      alu_sub:  alu_res = op1 - alu_b;
      alu_sll:  alu_res = op1 << shamt;
      alu_slt:  alu_res = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(alu_b)};
      alu_sltu: alu_res = {{(`XLEN-1){1'b0}}, op1 < alu_b};
      alu_xor:  alu_res = op1 ^ alu_b;
      alu_srl:  alu_res = op1 >> shamt;
      alu_sra:  alu_res = $unsigned($signed(op1) >>> shamt);
      alu_or:   alu_res = op1 | alu_b;
      alu_and:  alu_res = op1 & alu_b;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    mul_in.enable = live && (cur.unit == unit_mul);
    mul_in.op = cur.mul_op;
    mul_in.rdata1 = op1;
    mul_in.rdata2 = op2;

    div_in.enable = live && (cur.unit == unit_div);
    div_in.op = cur.div_op;
    div_in.rdata1 = op1;
    div_in.rdata2 = op2;
  end

  always_comb begin
    stall = 1'b0;
    wdata = alu_res;
    unique case (cur.unit)
      unit_mul: begin
        if (mul_out.ready) begin
          wdata = mul_out.result;
        end else begin
          stall = live;
        end
      end
      unit_div: begin
        if (div_out.ready) begin
          wdata = div_out.result;
        end else begin
          stall = live;
        end
      end
      default: wdata = alu_res;
    endcase

    wb.retired = live & ~stall;
    wb.wren = wb.retired & (cur.waddr != '0); // x0 is never written.
    wb.waddr = cur.waddr;
    wb.wdata = wdata;
  end

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      r_req <= init_exec_req;
      r_stall <= 1'b0;
    end else begin
      r_req <= cur;
      r_stall <= stall;
    end
  end

endmodule

//--- logic/exec_top.sv
module exec_top (
  input  logic                  clk,
  input  logic                  rst,
  input  exec_pkg::exec_req_t   req,
  output logic                  stall,
  output exec_pkg::writeback_t  wb
);
  import exec_pkg::*;

  muldiv_in_t  mul_in;
  muldiv_out_t mul_out;
  muldiv_in_t  div_in;
  muldiv_out_t div_out;

  execute_stage execute_stage_inst (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .mul_in  (mul_in),
    .mul_out (mul_out),
    .div_in  (div_in),
    .div_out (div_out),
    .stall   (stall),
    .wb      (wb)
  );

  // fixed latency pipeline.
  mul_unit mul_unit_inst (
    .clk     (clk),
    .rst     (rst),
    .mul_in  (mul_in),
    .mul_out (mul_out)
  );

  // one quotient bit per cycle.
  div_unit div_unit_inst (
    .clk     (clk),
    .rst     (rst),
    .div_in  (div_in),
    .div_out (div_out)
  );

endmodule

//--- testbench/exec_table.svh
// fixed entries, expected values worked out by hand.
task automatic load_table();
  // alu with register and immediate operands.
  add_alu(alu_add, 1, 1, 32'd5, 32'd7, 32'd0, 5'd1, 32'd12);
  add_alu(alu_add, 1, 0, 32'd100, 32'd0, 32'hFFFF_FFFF, 5'd2, 32'd99);
  add_alu(alu_sub, 1, 1, 32'd3, 32'd5, 32'd0, 5'd3, 32'hFFFF_FFFE);
  add_alu(alu_sll, 1, 0, 32'd1, 32'd0, 32'd4, 5'd4, 32'd16);
  add_alu(alu_srl, 1, 1, 32'h8000_0000, 32'd4, 32'd0, 5'd5, 32'h0800_0000);
  add_alu(alu_sra, 1, 1, 32'h8000_0000, 32'd4, 32'd0, 5'd6, 32'hF800_0000);
  add_alu(alu_slt, 1, 1, 32'hFFFF_FFFF, 32'd1, 32'd0, 5'd7, 32'd1);
  add_alu(alu_sltu, 1, 1, 32'hFFFF_FFFF, 32'd1, 32'd0, 5'd8, 32'd0);
  add_alu(alu_xor, 1, 1, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'd0, 5'd9, 32'hFF00_FF00);
  add_alu(alu_or, 1, 1, 32'h1234_0000, 32'h0000_5678, 32'd0, 5'd10, 32'h1234_5678);
  add_alu(alu_and, 1, 1, 32'hFFFF_0000, 32'h1234_5678, 32'd0, 5'd11, 32'h1234_0000);
  // x0 target and disabled operands.
  add_alu(alu_add, 1, 1, 32'd1, 32'd2, 32'd0, 5'd0, 32'd3);
  add_alu(alu_add, 0, 1, 32'd55, 32'd3, 32'd0, 5'd12, 32'd3);
  add_long(unit_mul, 2'(mul_mul), 0, 32'd7, 32'd9, 5'd13, 32'd0, 0);
  // multiplies.
  add_long(unit_mul, 2'(mul_mul), 1, 32'hFFFF_FFFF, 32'd2, 5'd14, 32'hFFFF_FFFE, 0);
  add_long(unit_mul, 2'(mul_mulh), 1, 32'hFFFF_FFFF, 32'd2, 5'd15, 32'hFFFF_FFFF, 0);
  add_long(unit_mul, 2'(mul_mulhsu), 1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd16, 32'hFFFF_FFFF, 0);
  add_long(unit_mul, 2'(mul_mulhu), 1, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd17, 32'hFFFF_FFFE, 0);
  add_long(unit_mul, 2'(mul_mulh), 1, 32'h8000_0000, 32'h8000_0000, 5'd18, 32'h4000_0000, 0);
  add_long(unit_mul, 2'(mul_mul), 1, 32'd3, 32'hFFFF_FFFC, 5'd19, 32'hFFFF_FFF4, 0);
  // divides, by zero and overflow.
  add_long(unit_div, 2'(div_div), 1, 32'hFFFF_FFF9, 32'd2, 5'd20, 32'hFFFF_FFFD, 0);
  add_long(unit_div, 2'(div_rem), 1, 32'hFFFF_FFF9, 32'd2, 5'd21, 32'hFFFF_FFFF, 0);
  add_long(unit_div, 2'(div_divu), 1, 32'hFFFF_FFF9, 32'd2, 5'd22, 32'h7FFF_FFFC, 0);
  add_long(unit_div, 2'(div_remu), 1, 32'hFFFF_FFF9, 32'd2, 5'd23, 32'd1, 0);
  add_long(unit_div, 2'(div_div), 1, 32'd20, 32'd0, 5'd24, 32'hFFFF_FFFF, 0);
  add_long(unit_div, 2'(div_rem), 1, 32'd20, 32'd0, 5'd25, 32'd20, 0);
  add_long(unit_div, 2'(div_divu), 1, 32'd20, 32'd0, 5'd26, 32'hFFFF_FFFF, 0);
  add_long(unit_div, 2'(div_div), 1, 32'h8000_0000, 32'hFFFF_FFFF, 5'd27, 32'h8000_0000, 0);
  add_long(unit_div, 2'(div_rem), 1, 32'h8000_0000, 32'hFFFF_FFFF, 5'd28, 32'd0, 0);
  add_long(unit_div, 2'(div_div), 1, 32'd100, 32'hFFFF_FFF9, 5'd29, 32'hFFFF_FFF2, 0);
  add_long(unit_div, 2'(div_rem), 1, 32'd100, 32'hFFFF_FFF9, 5'd30, 32'd2, 0);
  // squashed requests.
  add_clear(unit_div, 2'(div_div), 32'd40, 32'd3);
  add_clear(unit_mul, 2'(mul_mulhu), 32'd40, 32'd3);
  add_clear(unit_alu, 2'd0, 32'd40, 32'd3);
  // back to back, junk on req while stalled.
  add_long(unit_mul, 2'(mul_mul), 1, 32'd6, 32'd7, 5'd1, 32'd42, 1);
  add_long(unit_div, 2'(div_divu), 1, 32'd42, 32'd5, 5'd2, 32'd8, 1);
  add_long(unit_mul, 2'(mul_mulhu), 1, 32'h8000_0000, 32'd4, 5'd3, 32'd2, 1);
  add_long(unit_div, 2'(div_remu), 1, 32'd42, 32'd5, 5'd4, 32'd2, 1);
  add_long(unit_mul, 2'(mul_mul), 1, 32'd11, 32'd11, 5'd5, 32'd121, 1);
endtask

//--- testbench/exec_tb.sv
`include "exec_cfg.svh"

module exec_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import exec_pkg::*;

  typedef struct packed {
    exec_req_t   req;
    logic [31:0] exp_wdata;
    logic        exp_wren;
    logic        exp_retired;
    logic        no_stall;   // must finish in the presenting cycle.
    logic        scramble;   // drive junk on req while stalled.
  } entry_t;

  logic       clk;
  logic       rst;
  exec_req_t  req;
  logic       stall;
  writeback_t wb;
  entry_t     table_q[$];
  int         seed = 46584;
  int         cycle_count = 0;
  int         cycle_limit = 0;

  exec_top DUT (.clk(clk), .rst(rst), .req(req), .stall(stall), .wb(wb));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      fail_run($sformatf("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act));
    end
  endtask

  function automatic exec_req_t base_req();
    exec_req_t r;
    r = init_exec_req;
    r.valid = 1'b1;
    r.rden1 = 1'b1;
    r.rden2 = 1'b1;
    return r;
  endfunction

  function automatic logic [31:0] ref_result(input exec_req_t r);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] bi;
    logic [63:0] p;
    a = r.rden1 ? r.rdata1 : 32'h0;
    b = r.rden2 ? r.rdata2 : 32'h0;
    bi = r.rden2 ? b : r.imm;
    if (r.unit == unit_alu) begin
      case (r.alu_op)
        alu_add:  return a + bi;
        alu_sub:  return a - bi;
        alu_sll:  return a << bi[4:0];
        alu_slt:  return ($signed(a) < $signed(bi)) ? 32'd1 : 32'd0;
        alu_sltu: return (a < bi) ? 32'd1 : 32'd0;
        alu_xor:  return a ^ bi;
        alu_srl:  return a >> bi[4:0];
        alu_sra:  return $signed(a) >>> bi[4:0];
        alu_or:   return a | bi;
        alu_and:  return a & bi;
        default:  return 32'h0;
      endcase
    end
    if (r.unit == unit_mul) begin
      case (r.mul_op)
        mul_mulhsu: p = {{32{a[31]}}, a} * {32'h0, b};
        mul_mulhu:  p = {32'h0, a} * {32'h0, b};
        default:    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      endcase
      return (r.mul_op == mul_mul) ? p[31:0] : p[63:32];
    end
    if (b == 32'h0) begin
      return (r.div_op == div_rem || r.div_op == div_remu) ? a : 32'hFFFF_FFFF;
    end
    case (r.div_op)
      div_div: begin
        if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
          return a;
        end
        return $signed(a) / $signed(b);
      end
      div_rem: begin
        if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
          return 32'h0;
        end
        return $signed(a) % $signed(b);
      end
      div_divu: return a / b;
      default:  return a % b;
    endcase
  endfunction

  task automatic add_alu(input alu_op_e op, input logic rden1, input logic rden2,
                         input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm,
                         input logic [4:0] waddr, input logic [31:0] exp);
    entry_t e;
    e = '0;
    e.req = base_req();
    e.req.unit = unit_alu;
    e.req.alu_op = op;
    e.req.rden1 = rden1;
    e.req.rden2 = rden2;
    e.req.rdata1 = a;
    e.req.rdata2 = b;
    e.req.imm = imm;
    e.req.waddr = waddr;
    e.exp_wdata = exp;
    e.exp_wren = (waddr != 5'd0);
    e.exp_retired = 1'b1;
    e.no_stall = 1'b1;
    table_q.push_back(e);
  endtask

  task automatic add_long(input exec_unit_e unit, input logic [1:0] op, input logic rden2,
                          input logic [31:0] a, input logic [31:0] b, input logic [4:0] waddr,
                          input logic [31:0] exp, input logic scramble);
    entry_t e;
    e = '0;
    e.req = base_req();
    e.req.unit = unit;
    e.req.mul_op = mul_op_e'(op);
    e.req.div_op = div_op_e'(op);
    e.req.rden2 = rden2;
    e.req.rdata1 = a;
    e.req.rdata2 = b;
    e.req.waddr = waddr;
    e.exp_wdata = exp;
    e.exp_wren = (waddr != 5'd0);
    e.exp_retired = 1'b1;
    e.scramble = scramble;
    table_q.push_back(e);
  endtask

  task automatic add_clear(input exec_unit_e unit, input logic [1:0] op,
                           input logic [31:0] a, input logic [31:0] b);
    entry_t e;
    e = '0;
    e.req = base_req();
    e.req.clear = 1'b1;
    e.req.unit = unit;
    e.req.mul_op = mul_op_e'(op);
    e.req.div_op = div_op_e'(op);
    e.req.rdata1 = a;
    e.req.rdata2 = b;
    e.req.waddr = 5'd9;
    e.no_stall = 1'b1;
    table_q.push_back(e);
  endtask

  `include "exec_table.svh"

  task automatic add_random();
    entry_t      e;
    logic [31:0] bits;
    logic [1:0]  u;
    logic [3:0]  aop;
    bits = $random(seed);
    u = bits[15:13] % 3;
    aop = bits[31:16] % 10;
    e = '0;
    e.req = base_req();
    e.req.unit = exec_unit_e'(u);
    e.req.alu_op = alu_op_e'(aop);
    e.req.mul_op = mul_op_e'(bits[1:0]);
    e.req.div_op = div_op_e'(bits[3:2]);
    e.req.rden1 = bits[4] | bits[5]; // mostly enabled.
    e.req.rden2 = bits[6] | bits[7];
    e.req.waddr = bits[12:8];
    e.req.rdata1 = $random(seed);
    e.req.rdata2 = $random(seed);
    e.req.imm = $random(seed);
    e.exp_wdata = ref_result(e.req);
    e.exp_wren = (e.req.waddr != 5'd0);
    e.exp_retired = 1'b1;
    e.no_stall = (e.req.unit == unit_alu);
    e.scramble = 1'b1;
    table_q.push_back(e);
  endtask

  function automatic exec_req_t junk_req();
    logic [127:0] raw;
    raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
    return raw[$bits(exec_req_t)-1:0];
  endfunction

  task automatic apply_entry(input entry_t e);
    @(negedge clk);
    req = e.req;
    #1;
    if (e.no_stall) begin
      check_value("stall", 32'd0, {31'd0, stall});
    end
    while (stall) begin
      @(negedge clk);
      if (e.scramble) begin
        req = junk_req();
      end
      #1;
    end
    check_value("wb.retired", {31'd0, e.exp_retired}, {31'd0, wb.retired});
    check_value("wb.wren", {31'd0, e.exp_wren}, {31'd0, wb.wren});
    if (e.exp_retired) begin
      check_value("wb.waddr", {27'd0, e.req.waddr}, {27'd0, wb.waddr});
      check_value("wb.wdata", e.exp_wdata, wb.wdata);
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      fail_run("timeout: the DUT did not finish the requests in time");
    end
  end

  initial begin
    rst = 1'b0;
    req = init_exec_req;
    load_table();
    repeat (40) add_random();
    cycle_limit = table_q.size() * (`XLEN + 4) + 50;
    repeat (5) @(negedge clk);
    rst = 1'b1;
    #1;
    check_value("stall", 32'd0, {31'd0, stall});
    check_value("wb.retired", 32'd0, {31'd0, wb.retired});
    check_value("wb.wren", 32'd0, {31'd0, wb.wren});
    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end
    @(negedge clk);
    req = init_exec_req;
    $display("Verification passed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+logic
+incdir+testbench
logic/exec_pkg.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/execute_stage.sv
logic/exec_top.sv
testbench/exec_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/exec_pkg.sv
      - logic/mul_unit.sv
      - logic/div_unit.sv
      - logic/execute_stage.sv
      - logic/exec_top.sv
  - target: simulation
    include_dirs:
      - logic
      - testbench
    files:
      - testbench/exec_tb.sv
